/* hdl/axi_delayer.sv */
`timescale 1ns/10ps

module axi_delayer #(
   parameter int                 H_WIDTH     = 1920,
   parameter int                 V_HEIGHT    = 1080,
   parameter axi_pkg::axi_addr_t BASE        = 32'h2000_0000,
   parameter int                 RFIFO_DEPTH = 24,
   parameter int                 WFIFO_DEPTH = 64
) (
   input  logic                clk_i,
   input  logic                rst_ni,
   input  logic                ren_i,
   input  logic                wen_i,
   input  logic                vs_i,
   input  logic                de_i,
   input  video_pkg::pixel_t   data_i,
   output video_pkg::pixel_t   data_o,
   output logic                m_axi_arvalid_o,
   input  logic                m_axi_arready_i,
   output axi_pkg::axi_addr_t  m_axi_araddr_o,
   input  logic                m_axi_rvalid_i,
   output logic                m_axi_rready_o,
   input  axi_pkg::axi_data_t  m_axi_rdata_i,
   input  logic                m_axi_rlast_i,
   output logic                m_axi_awvalid_o,
   input  logic                m_axi_awready_i,
   output axi_pkg::axi_addr_t  m_axi_awaddr_o,
   output logic                m_axi_wvalid_o,
   input  logic                m_axi_wready_i,
   output axi_pkg::axi_data_t  m_axi_wdata_o,
   output logic                m_axi_wlast_o,
   input  logic                m_axi_bvalid_i,
   output logic                m_axi_bready_o
);
   import video_pkg::*;
   import axi_pkg::*;

   localparam int        FRAME_BYTES = H_WIDTH * V_HEIGHT * PIXEL_BYTES;
   localparam axi_addr_t BANK_A      = BASE;
   localparam axi_addr_t BANK_B      = BASE + axi_addr_t'(FRAME_BYTES);

   logic      vs_q;
   logic      vs_rise;
   logic      bank_q;
   axi_addr_t wr_base;
   axi_addr_t rd_base;
   axi_data_t wf_data;
   logic      wf_avail;
   logic      wf_pop;

   stream_if #(.W(PIXEL_BYTES * 8)) w_pix_if ();
   stream_if #(.W(BEAT_BYTES * 8))  w_word_if ();
   stream_if #(.W(BEAT_BYTES * 8))  r_beat_if ();
   stream_if #(.W(PIXEL_BYTES * 8)) r_pix_if ();

   assign vs_rise = vs_i && !vs_q;

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         vs_q   <= 1'b0;
         bank_q <= 1'b0;
      end else begin
         vs_q   <= vs_i;
         bank_q <= bank_q ^ vs_rise;
      end
   end

   // sampled at vs_rise, first frame writes bank b
   assign wr_base = bank_q ? BANK_A : BANK_B;
   assign rd_base = bank_q ? BANK_B : BANK_A;

   assign w_pix_if.srst  = vs_rise;
   assign w_word_if.srst = vs_rise;
   assign r_beat_if.srst = vs_rise;
   assign r_pix_if.srst  = vs_rise;
   assign w_pix_if.val   = de_i;
   assign w_pix_if.data  = data_i;

   repacker #(.IN(PIXEL_BYTES), .OUT(BEAT_BYTES), .BUFF(PIXEL_BYTES + BEAT_BYTES))
      w_pack_inst (.clk_i(clk_i), .rst_ni(rst_ni), .in_i(w_pix_if), .out_o(w_word_if));

   frame_fifo #(.WIDTH(BEAT_BYTES * 8), .DEPTH(WFIFO_DEPTH), .BURST_LEN(BURST_BEATS))
      w_fifo_inst (
         .clk_i(clk_i), .rst_ni(rst_ni), .in_i(w_word_if), .pop_i(wf_pop),
         .data_o(wf_data), .burst_avail_o(wf_avail)
      );

   frame_writer #(.FRAME_BYTES(FRAME_BYTES)) writer_inst (
      .clk_i(clk_i), .rst_ni(rst_ni), .frame_start_i(vs_rise), .bank_base_i(wr_base),
      .enable_i(wen_i), .burst_avail_i(wf_avail), .fifo_data_i(wf_data), .fifo_pop_o(wf_pop),
      .m_axi_awready_i(m_axi_awready_i), .m_axi_awvalid_o(m_axi_awvalid_o),
      .m_axi_awaddr_o(m_axi_awaddr_o), .m_axi_wready_i(m_axi_wready_i),
      .m_axi_wvalid_o(m_axi_wvalid_o), .m_axi_wdata_o(m_axi_wdata_o),
      .m_axi_wlast_o(m_axi_wlast_o)
   );

   frame_reader #(.FRAME_BYTES(FRAME_BYTES)) reader_inst (
      .clk_i(clk_i), .rst_ni(rst_ni), .frame_start_i(vs_rise), .bank_base_i(rd_base),
      .enable_i(ren_i), .m_axi_arready_i(m_axi_arready_i), .m_axi_arvalid_o(m_axi_arvalid_o),
      .m_axi_araddr_o(m_axi_araddr_o), .m_axi_rvalid_i(m_axi_rvalid_i),
      .m_axi_rdata_i(m_axi_rdata_i), .m_axi_rlast_i(m_axi_rlast_i),
      .m_axi_rready_o(m_axi_rready_o), .beats_o(r_beat_if)
   );

   repacker #(.IN(BEAT_BYTES), .OUT(PIXEL_BYTES), .BUFF(2 * BEAT_BYTES * PIXEL_BYTES))
      r_pack_inst (.clk_i(clk_i), .rst_ni(rst_ni), .in_i(r_beat_if), .out_o(r_pix_if));

   frame_fifo #(.WIDTH(PIXEL_BYTES * 8), .DEPTH(RFIFO_DEPTH), .BURST_LEN(1))
      r_fifo_inst (
         .clk_i(clk_i), .rst_ni(rst_ni), .in_i(r_pix_if), .pop_i(de_i),
         .data_o(data_o), .burst_avail_o()
      );

   assign m_axi_bready_o = 1'b1;  // responses not checked

endmodule

/* hdl/axi_pkg.sv */
package axi_pkg;

   typedef logic [31:0] axi_addr_t;
   typedef logic [63:0] axi_data_t;

   localparam int BEAT_BYTES  = 8;
   localparam int BURST_BEATS = 16;
   localparam int BURST_BYTES = BEAT_BYTES * BURST_BEATS;

   // fixed burst shape seen by the memory side
   localparam int AXI_LEN        = BURST_BEATS - 1;
   localparam int AXI_SIZE       = 3;  // 8 bytes per beat
   localparam int AXI_BURST_INCR = 1;

   typedef enum logic [1:0] {
      WR_IDLE,
      WR_ADDR,  // aw pending
      WR_DATA   // beats pending
   } wr_state_t;

endpackage

/* hdl/frame_fifo.sv */
`timescale 1ns/10ps

module frame_fifo #(
   parameter int WIDTH     = 64,
   parameter int DEPTH     = 64,
   parameter int BURST_LEN = 16
) (
   input  logic             clk_i,
   input  logic             rst_ni,
   stream_if.snk            in_i,
   input  logic             pop_i,
   output logic [WIDTH-1:0] data_o,
   output logic             burst_avail_o
);
   localparam int AW = $clog2(DEPTH);
   localparam int CW = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem_q [DEPTH];
   logic [AW-1:0]    wr_ptr_q;
   logic [AW-1:0]    rd_ptr_q;
   logic [CW-1:0]    count_q;
   logic             push;
   logic             pop;

   assign in_i.rdy      = count_q != CW'(DEPTH);
   assign push          = in_i.val && in_i.rdy;
   assign pop           = pop_i && (count_q != '0);  // empty pop leaves head as is
   assign data_o        = mem_q[rd_ptr_q];
   assign burst_avail_o = count_q >= CW'(BURST_LEN);

   always_ff @(posedge clk_i) begin
      if (push) begin
         mem_q[wr_ptr_q] <= in_i.data;
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else if (in_i.srst) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

endmodule

/* hdl/frame_reader.sv */
`timescale 1ns/10ps

module frame_reader #(
   parameter int FRAME_BYTES = 384
) (
   input  logic               clk_i,
   input  logic               rst_ni,
   input  logic               frame_start_i,
   input  axi_pkg::axi_addr_t bank_base_i,
   input  logic               enable_i,
   input  logic               m_axi_arready_i,
   output logic               m_axi_arvalid_o,
   output axi_pkg::axi_addr_t m_axi_araddr_o,
   input  logic               m_axi_rvalid_i,
   input  axi_pkg::axi_data_t m_axi_rdata_i,
   input  logic               m_axi_rlast_i,
   output logic               m_axi_rready_o,
   stream_if.src              beats_o
);
   import axi_pkg::*;

   localparam int NBURST = FRAME_BYTES / BURST_BYTES;
   localparam int PW     = $clog2(NBURST + 1);

   logic          arvalid_q;
   axi_addr_t     addr_q;
   axi_addr_t     last_q;
   logic [PW-1:0] pend_q;  // bursts requested, not yet fully returned
   logic          beat_val_q;
   axi_data_t     beat_data_q;
   logic          ar_fire;
   logic          r_fire;
   logic          burst_done;

   assign ar_fire    = arvalid_q && m_axi_arready_i;
   assign r_fire     = m_axi_rvalid_i && m_axi_rready_o;
   assign burst_done = r_fire && m_axi_rlast_i;

   assign m_axi_arvalid_o = arvalid_q;
   assign m_axi_araddr_o  = addr_q;
   assign m_axi_rready_o  = beats_o.rdy && (pend_q != '0);
   assign beats_o.val     = beat_val_q;
   assign beats_o.data    = beat_data_q;

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         arvalid_q <= 1'b0;
         addr_q    <= '0;
         last_q    <= '0;
      end else if (frame_start_i) begin
         arvalid_q <= enable_i;
         addr_q    <= bank_base_i;
         last_q    <= bank_base_i + axi_addr_t'(FRAME_BYTES - BURST_BYTES);
      end else if (ar_fire) begin
         arvalid_q <= enable_i && (addr_q != last_q);  // next burst right away
         addr_q    <= addr_q + axi_addr_t'(BURST_BYTES);
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         pend_q <= '0;
      end else if (frame_start_i) begin
         pend_q <= '0;
      end else begin
         case ({ar_fire, burst_done})
            2'b10:   pend_q <= pend_q + 1'b1;
            2'b01:   pend_q <= pend_q - 1'b1;
            default: pend_q <= pend_q;
         endcase
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         beat_val_q <= 1'b0;
      end else if (frame_start_i) begin
         beat_val_q <= 1'b0;
      end else if (r_fire) begin
         beat_val_q <= 1'b1;
      end else if (beats_o.rdy) begin
         beat_val_q <= 1'b0;  // taken by the packer
      end
   end

   always_ff @(posedge clk_i) begin
      if (r_fire) begin
         beat_data_q <= m_axi_rdata_i;
      end
   end

endmodule

/* hdl/frame_writer.sv */
`timescale 1ns/10ps

module frame_writer #(
   parameter int FRAME_BYTES = 384
) (
   input  logic               clk_i,
   input  logic               rst_ni,
   input  logic               frame_start_i,
   input  axi_pkg::axi_addr_t bank_base_i,
   input  logic               enable_i,
   input  logic               burst_avail_i,
   input  axi_pkg::axi_data_t fifo_data_i,
   output logic               fifo_pop_o,
   input  logic               m_axi_awready_i,
   output logic               m_axi_awvalid_o,
   output axi_pkg::axi_addr_t m_axi_awaddr_o,
   input  logic               m_axi_wready_i,
   output logic               m_axi_wvalid_o,
   output axi_pkg::axi_data_t m_axi_wdata_o,
   output logic               m_axi_wlast_o
);
   import axi_pkg::*;

   wr_state_t state_q;
   axi_addr_t addr_q;
   axi_addr_t last_q;
   logic      done_q;  // last burst of the frame sent
   logic [3:0] beat_q;
   logic      w_fire;

   assign m_axi_awvalid_o = state_q == WR_ADDR;
   assign m_axi_awaddr_o  = addr_q;
   assign m_axi_wvalid_o  = state_q == WR_DATA;
   assign m_axi_wdata_o   = fifo_data_i;  // fifo head is the current beat
   assign m_axi_wlast_o   = m_axi_wvalid_o && (beat_q == 4'(AXI_LEN));

   assign w_fire     = m_axi_wvalid_o && m_axi_wready_i;
   assign fifo_pop_o = w_fire;

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         state_q <= WR_IDLE;
         addr_q  <= '0;
         last_q  <= '0;
         done_q  <= 1'b1;  // wait for the first frame
         beat_q  <= '0;
      end else if (frame_start_i) begin
         state_q <= WR_IDLE;
         addr_q  <= bank_base_i;
         last_q  <= bank_base_i + axi_addr_t'(FRAME_BYTES - BURST_BYTES);
         done_q  <= 1'b0;
         beat_q  <= '0;
      end else begin
         case (state_q)
            WR_IDLE: begin
               if (enable_i && burst_avail_i && !done_q) begin
                  state_q <= WR_ADDR;
               end
            end
            WR_ADDR: begin
               if (m_axi_awready_i) begin
                  state_q <= WR_DATA;
                  beat_q  <= '0;
               end
            end
            WR_DATA: begin
               if (w_fire) begin
                  beat_q <= beat_q + 1'b1;
                  if (beat_q == 4'(AXI_LEN)) begin
                     state_q <= WR_IDLE;
                     done_q  <= addr_q == last_q;
                     addr_q  <= addr_q + axi_addr_t'(BURST_BYTES);
                  end
               end
            end
            default: state_q <= WR_IDLE;
         endcase
      end
   end

endmodule

/* hdl/repacker.sv */
`timescale 1ns/10ps

module repacker #(
   parameter int IN   = 3,
   parameter int OUT  = 8,
   parameter int BUFF = 11
) (
   input logic    clk_i,
   input logic    rst_ni,
   stream_if.snk  in_i,
   stream_if.src  out_o
);
   localparam int FW = $clog2(BUFF + 1);

   logic [BUFF*8-1:0] buf_q;
   logic [BUFF*8-1:0] buf_d;
   logic [FW-1:0]     fill_q;
   logic [FW-1:0]     fill_d;
   logic              in_fire;
   logic              out_fire;

   assign in_i.rdy   = (BUFF - int'(fill_q)) >= IN;
   assign out_o.val  = int'(fill_q) >= OUT;
   assign out_o.data = buf_q[OUT*8-1:0];

   assign in_fire  = in_i.val && in_i.rdy;
   assign out_fire = out_o.val && out_o.rdy;

   always_comb begin
      buf_d  = buf_q;
      fill_d = fill_q;
      if (out_fire) begin
         buf_d  = buf_d >> (OUT * 8);  // drop emitted bytes
         fill_d = fill_d - FW'(OUT);
      end
      if (in_fire) begin
         // free bytes above fill are zero, so an or places the new ones
         buf_d  = buf_d | ({{((BUFF - IN) * 8){1'b0}}, in_i.data} << {fill_d, 3'b000});
         fill_d = fill_d + FW'(IN);
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         buf_q  <= '0;
         fill_q <= '0;
      end else if (in_i.srst) begin
         buf_q  <= '0;
         fill_q <= '0;
      end else begin
         buf_q  <= buf_d;
         fill_q <= fill_d;
      end
   end

endmodule

/* hdl/stream_if.sv */
`timescale 1ns/10ps

interface stream_if #(
   parameter int W = 8
) ();
   logic         srst;  // frame restart
   logic         val;
   logic         rdy;
   logic [W-1:0] data;

   modport src (input srst, input rdy, output val, output data);
   modport snk (input srst, input val, input data, output rdy);
endinterface

/* hdl/video_pkg.sv */
package video_pkg;

   // one rgb pixel, blue in the low byte
   typedef logic [23:0] pixel_t;

   localparam int PIXEL_BYTES = 3;

endpackage

/* project.f */
hdl/video_pkg.sv
hdl/axi_pkg.sv
hdl/stream_if.sv
hdl/repacker.sv
hdl/frame_fifo.sv
hdl/frame_reader.sv
hdl/frame_writer.sv
hdl/axi_delayer.sv
tests/clk_gen.sv
tests/axi_mem_model.sv
tests/axi_delayer_props.sv
tests/tb_axi_delayer.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the frame delayer testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_axi_delayer \
   -f project.f -o tb_axi_delayer > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_axi_delayer > sim.log 2>&1 ; cat sim.log
! grep -q "Test FAILED" sim.log && grep -q "Test OK" sim.log || exit 1

/* tests/axi_delayer_props.sv */
`timescale 1ns/10ps

module axi_delayer_props (
   input logic               clk_i,
   input logic               rst_ni,
   input logic               m_axi_arvalid_o,
   input logic               m_axi_arready_i,
   input axi_pkg::axi_addr_t m_axi_araddr_o,
   input logic               m_axi_awvalid_o,
   input logic               m_axi_awready_i,
   input axi_pkg::axi_addr_t m_axi_awaddr_o,
   input logic               m_axi_wvalid_o,
   input logic               m_axi_wready_i,
   input logic               m_axi_wlast_o
);
   logic [3:0] w_beat_q;

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         w_beat_q <= '0;
      end else if (m_axi_wvalid_o && m_axi_wready_i) begin
         w_beat_q <= w_beat_q + 4'd1;  // wraps every burst
      end
   end

   ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      m_axi_arvalid_o && !m_axi_arready_i |=> m_axi_arvalid_o && $stable(m_axi_araddr_o))
      else $error("arvalid or araddr changed before arready");

   aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      m_axi_awvalid_o && !m_axi_awready_i |=> m_axi_awvalid_o && $stable(m_axi_awaddr_o))
      else $error("awvalid or awaddr changed before awready");

   w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      m_axi_wvalid_o && !m_axi_wready_i |=> m_axi_wvalid_o)
      else $error("wvalid dropped before wready");

   wlast_pos: assert property (@(posedge clk_i) disable iff (!rst_ni)
      m_axi_wvalid_o && m_axi_wready_i |-> m_axi_wlast_o == (w_beat_q == 4'd15))
      else $error("wlast not on beat 16 of the burst");

endmodule

bind axi_delayer axi_delayer_props props_inst (.*);

/* tests/axi_mem_model.sv */
`timescale 1ns/10ps

module axi_mem_model (
   input  logic               clk_i,
   input  logic               rst_ni,
   input  logic               stall_i,
   input  logic               arvalid_i,
   output logic               arready_o,
   input  axi_pkg::axi_addr_t araddr_i,
   output logic               rvalid_o,
   input  logic               rready_i,
   output axi_pkg::axi_data_t rdata_o,
   output logic               rlast_o,
   input  logic               awvalid_i,
   output logic               awready_o,
   input  axi_pkg::axi_addr_t awaddr_i,
   input  logic               wvalid_i,
   output logic               wready_o,
   input  axi_pkg::axi_data_t wdata_i,
   input  logic               wlast_i,
   output logic               bvalid_o,
   input  logic               bready_i
);
   import axi_pkg::*;

   localparam logic [31:0] LFSR_SEED = 32'd87464;
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

   axi_data_t   mem [axi_addr_t];
   axi_addr_t   ar_q[$];
   axi_addr_t   aw_q[$];
   axi_addr_t   ar_log[$];  // accepted addresses that the testbench clears per frame
   axi_addr_t   aw_log[$];
   int unsigned w_beats;
   int unsigned r_beat;
   int unsigned w_beat;
   logic [31:0] lfsr_q;

   // unwritten words read back as their own address
   function automatic axi_data_t peek(input axi_addr_t a);
      if (mem.exists(a)) begin
         return mem[a];
      end
      return {a, ~a};
   endfunction

   // stall when two lfsr bits are both set
   function automatic logic stall_roll();
      logic a;
      logic b;
      a      = lfsr_q[0];
      lfsr_q = (lfsr_q >> 1) ^ (a ? LFSR_TAPS : 32'h0);
      b      = lfsr_q[0];
      lfsr_q = (lfsr_q >> 1) ^ (b ? LFSR_TAPS : 32'h0);
      return a && b;
   endfunction

   always @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         arready_o <= 1'b0;
         awready_o <= 1'b0;
         wready_o  <= 1'b0;
         rvalid_o  <= 1'b0;
         rlast_o   <= 1'b0;
         rdata_o   <= '0;
         bvalid_o  <= 1'b0;
         lfsr_q    = LFSR_SEED;
         r_beat    = 0;
         w_beat    = 0;
         w_beats   = 0;
         ar_q.delete();
         aw_q.delete();
      end else begin
         if (arvalid_i && arready_o) begin
            ar_q.push_back(araddr_i);
            ar_log.push_back(araddr_i);
         end
         if (awvalid_i && awready_o) begin
            aw_q.push_back(awaddr_i);
            aw_log.push_back(awaddr_i);
         end
         if (wvalid_i && wready_o && aw_q.size() != 0) begin
            mem[aw_q[0] + axi_addr_t'(w_beat * BEAT_BYTES)] = wdata_i;
            w_beats++;
            if (wlast_i) begin
               void'(aw_q.pop_front());
               w_beat = 0;
            end else begin
               w_beat++;
            end
         end
         bvalid_o <= (wvalid_i && wready_o && wlast_i) || (bvalid_o && !bready_i);
         if (rvalid_o && rready_i) begin
            if (r_beat == BURST_BEATS - 1) begin
               void'(ar_q.pop_front());
               r_beat = 0;
            end else begin
               r_beat++;
            end
         end
         if (ar_q.size() != 0) begin
            rvalid_o <= 1'b1;
            rdata_o  <= peek(ar_q[0] + axi_addr_t'(r_beat * BEAT_BYTES));
            rlast_o  <= r_beat == BURST_BEATS - 1;
         end else begin
            rvalid_o <= 1'b0;
            rlast_o  <= 1'b0;
         end
         arready_o <= !(stall_i && stall_roll());
         awready_o <= !(stall_i && stall_roll());
         wready_o  <= !(stall_i && stall_roll());
      end
   end

endmodule

/* tests/clk_gen.sv */
`timescale 1ns/10ps

module clk_gen #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 2
) (
   output logic clk_o,
   output logic rst_no
);
   initial begin
      clk_o  = 1'b0;
      rst_no = 1'b0;
      fork
         forever #(PERIOD_NS / 2) clk_o = ~clk_o;
         begin
            repeat (RESET_CYCLES) @(posedge clk_o);
            @(negedge clk_o);
            rst_no = 1'b1;  // released away from the active edge
         end
      join
   end

endmodule

/* tests/tb_axi_delayer.sv */
`timescale 1ns/10ps

module tb_axi_delayer;
   import video_pkg::*;
   import axi_pkg::*;

   localparam int          H_WIDTH      = 16;
   localparam int          V_HEIGHT     = 8;
   localparam int          NPIX         = H_WIDTH * V_HEIGHT;
   localparam int          FRAME_BYTES  = NPIX * PIXEL_BYTES;
   localparam int          NWORDS       = FRAME_BYTES / BEAT_BYTES;
   localparam int          NBURST       = FRAME_BYTES / BURST_BYTES;
   localparam axi_addr_t   BASE         = 32'h0001_0000;
   localparam axi_addr_t   BANK_A       = BASE;
   localparam axi_addr_t   BANK_B       = BASE + axi_addr_t'(FRAME_BYTES);
   localparam int          BLANK_CYCLES = 64;
   localparam int          FRAME_CYCLES = 2 * NPIX;  // one pixel every other cycle
   localparam int          NUM_FRAMES   = 9;
   localparam int          TIMEOUT_NS   = NUM_FRAMES * (FRAME_CYCLES + BLANK_CYCLES) * 4 * 8;
   localparam int          WRITE_WAIT   = 400;
   localparam logic [31:0] LFSR_SEED    = 32'd87464;
   localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

   logic      clk;
   logic      rst_n;
   logic      ren_i;
   logic      wen_i;
   logic      vs_i;
   logic      de_i;
   pixel_t    data_i;
   pixel_t    data_o;
   logic      stall_en;
   logic      arvalid, arready, rvalid, rready, rlast;
   logic      awvalid, awready, wvalid, wready, wlast, bvalid, bready;
   axi_addr_t araddr, awaddr;
   axi_data_t rdata, wdata;

   logic [31:0] rand_q;
   int          frame_no;
   logic        prev_written;
   pixel_t      cur_pix [NPIX];
   pixel_t      prev_pix [NPIX];

   clk_gen clk_gen_inst (.clk_o(clk), .rst_no(rst_n));

   axi_delayer #(
      .H_WIDTH(H_WIDTH), .V_HEIGHT(V_HEIGHT), .BASE(BASE),
      .RFIFO_DEPTH(24), .WFIFO_DEPTH(64)
   ) axi_delayer_inst (
      .clk_i(clk), .rst_ni(rst_n), .ren_i(ren_i), .wen_i(wen_i), .vs_i(vs_i),
      .de_i(de_i), .data_i(data_i), .data_o(data_o),
      .m_axi_arvalid_o(arvalid), .m_axi_arready_i(arready), .m_axi_araddr_o(araddr),
      .m_axi_rvalid_i(rvalid), .m_axi_rready_o(rready), .m_axi_rdata_i(rdata),
      .m_axi_rlast_i(rlast), .m_axi_awvalid_o(awvalid), .m_axi_awready_i(awready),
      .m_axi_awaddr_o(awaddr), .m_axi_wvalid_o(wvalid), .m_axi_wready_i(wready),
      .m_axi_wdata_o(wdata), .m_axi_wlast_o(wlast), .m_axi_bvalid_i(bvalid),
      .m_axi_bready_o(bready)
   );

   axi_mem_model mem_inst (
      .clk_i(clk), .rst_ni(rst_n), .stall_i(stall_en),
      .arvalid_i(arvalid), .arready_o(arready), .araddr_i(araddr),
      .rvalid_o(rvalid), .rready_i(rready), .rdata_o(rdata), .rlast_o(rlast),
      .awvalid_i(awvalid), .awready_o(awready), .awaddr_i(awaddr),
      .wvalid_i(wvalid), .wready_o(wready), .wdata_i(wdata), .wlast_i(wlast),
      .bvalid_o(bvalid), .bready_i(bready)
   );

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Test FAILED");
      $fatal(1, "simulation stopped at first error");
   endtask

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] r;
      logic        b;
      r = '0;
      for (int i = 0; i < n; i++) begin
         b      = rand_q[0];
         rand_q = (rand_q >> 1) ^ (b ? LFSR_TAPS : 32'h0);
         r      = {r[30:0], b};
      end
      return r;
   endfunction

   // pixel stream laid out byte by byte with the low byte first
   function automatic axi_data_t pack_word(input int k);
      axi_data_t w;
      int        b;
      for (int j = 0; j < BEAT_BYTES; j++) begin
         b            = k * BEAT_BYTES + j;
         w[8*j +: 8]  = cur_pix[b / PIXEL_BYTES][8*(b % PIXEL_BYTES) +: 8];
      end
      return w;
   endfunction

   task automatic check_pixel(input pixel_t act, input pixel_t exp, input string what);
      if (act !== exp) begin
         abort_run($sformatf("Fail %0d ns: %s got %h, expected %h", $time, what, act, exp));
      end
   endtask

   task automatic check_word(input axi_data_t act, input axi_data_t exp, input string what);
      if (act !== exp) begin
         abort_run($sformatf("Fail %0d ns: %s got %h, expected %h", $time, what, act, exp));
      end
   endtask

   task automatic check_addr(input axi_addr_t act, input axi_addr_t exp, input string what);
      if (act !== exp) begin
         abort_run($sformatf("Fail %0d ns: %s got %h, expected %h", $time, what, act, exp));
      end
   endtask

   task automatic check_count(input int act, input int exp, input string what);
      if (act != exp) begin
         abort_run($sformatf("Fail %0d ns: %s got %0d, expected %0d", $time, what, act, exp));
      end
   endtask

   // vsync and blanking before the pixels and the burst and memory checks
   task automatic run_frame(input logic wen, input logic ren);
      axi_addr_t   wr_bank;
      axi_addr_t   rd_bank;
      int unsigned w_start;
      int          waited;
      frame_no++;
      wr_bank = frame_no[0] ? BANK_B : BANK_A;
      rd_bank = frame_no[0] ? BANK_A : BANK_B;
      @(negedge clk);
      mem_inst.aw_log.delete();
      mem_inst.ar_log.delete();
      w_start = mem_inst.w_beats;
      wen_i   = wen;
      ren_i   = ren;
      vs_i    = 1'b1;
      @(negedge clk);
      vs_i = 1'b0;
      repeat (BLANK_CYCLES) @(negedge clk);
      for (int p = 0; p < NPIX; p++) begin
         cur_pix[p] = pixel_t'(take_bits(24));
         de_i       = 1'b1;
         data_i     = cur_pix[p];
         if (ren && prev_written) begin
            check_pixel(data_o, prev_pix[p], $sformatf("data_o pixel %0d", p));
         end
         @(negedge clk);
         de_i   = 1'b0;
         data_i = '0;
         @(negedge clk);
      end
      waited = 0;
      while (wen && int'(mem_inst.w_beats - w_start) < NWORDS) begin
         if (waited >= WRITE_WAIT) begin
            abort_run("write bursts of the frame did not complete in time");
         end else begin
            waited++;
            @(negedge clk);
         end
      end
      if (wen) begin
         check_count(mem_inst.aw_log.size(), NBURST, "aw handshakes");
         foreach (mem_inst.aw_log[i]) begin
            check_addr(mem_inst.aw_log[i], wr_bank + axi_addr_t'(i * BURST_BYTES), "awaddr");
         end
         for (int k = 0; k < NWORDS; k++) begin
            check_word(mem_inst.peek(wr_bank + axi_addr_t'(k * BEAT_BYTES)), pack_word(k),
                       $sformatf("memory word %0d", k));
         end
      end else begin
         check_count(mem_inst.aw_log.size(), 0, "aw handshakes with wen low");
         check_count(int'(mem_inst.w_beats - w_start), 0, "w beats with wen low");
      end
      if (ren) begin
         check_count(mem_inst.ar_log.size(), NBURST, "ar handshakes");
         foreach (mem_inst.ar_log[i]) begin
            check_addr(mem_inst.ar_log[i], rd_bank + axi_addr_t'(i * BURST_BYTES), "araddr");
         end
      end else begin
         check_count(mem_inst.ar_log.size(), 0, "ar handshakes with ren low");
      end
      prev_pix     = cur_pix;
      prev_written = wen;
   endtask

   task automatic reset_outputs();
      wait (rst_n === 1'b1);
      @(negedge clk);
      if (arvalid !== 1'b0 || awvalid !== 1'b0 || wvalid !== 1'b0 || rready !== 1'b0) begin
         abort_run("a valid or rready output is not low after reset");
      end
      if (bready !== 1'b1) begin
         abort_run("bready is not high after reset");
      end
   endtask

   task automatic write_packing();
      run_frame(1'b1, 1'b0);
   endtask

   task automatic frame_delay();
      repeat (3) run_frame(1'b1, 1'b1);
   endtask

   task automatic enable_gating();
      run_frame(1'b0, 1'b1);
      run_frame(1'b1, 1'b0);
   endtask

   task automatic back_pressure();
      @(negedge clk);
      stall_en = 1'b1;
      repeat (3) run_frame(1'b1, 1'b1);
      stall_en = 1'b0;
   endtask

   initial begin
      #(TIMEOUT_NS);
      abort_run("watchdog timeout, the tests did not finish");
   end

   initial begin
      rand_q       = LFSR_SEED;
      frame_no     = 0;
      prev_written = 1'b0;
      stall_en     = 1'b0;
      ren_i        = 1'b0;
      wen_i        = 1'b0;
      vs_i         = 1'b0;
      de_i         = 1'b0;
      data_i       = '0;
      reset_outputs();
      write_packing();
      frame_delay();
      enable_gating();
      back_pressure();
      $display("Test OK");
      $finish;
   end

endmodule
